// File: common/conv_pkg.sv
`default_nettype none

package conv_pkg;

    // geometry of the image, the kernels and the valid output map.
    localparam int IMG_DIM  = 8;
    localparam int K_DIM    = 3;
    localparam int OUT_DIM  = IMG_DIM - K_DIM + 1;
    localparam int NUM_FILT = 3;
    localparam int NUM_TAPS = K_DIM * K_DIM;

    typedef logic        [7:0]  pixel_t;
    typedef logic signed [7:0]  weight_t;
    typedef logic signed [19:0] acc_t;   // nine 17-bit products fit with room to spare.
    typedef logic        [3:0]  tap_t;

    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } pos_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        RUN,
        COMMIT,
        DONE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        MAC_HOLD,
        MAC_CLEAR,
        MAC_ACC
    } mac_op_e;

endpackage

`default_nettype wire

// File: common/axil_pkg.sv
`default_nettype none

package axil_pkg;

    localparam int ADDR_W = 12;
    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              valid;
    } axil_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              valid;
    } axil_w_t;

    typedef struct packed {
        axil_resp_e resp;
        logic       valid;
    } axil_b_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              valid;
    } axil_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        axil_resp_e        resp;
        logic              valid;
    } axil_r_t;

    // the register map gives byte addresses of whole 32-bit words.
    localparam logic [ADDR_W-1:0] IMG_BASE  = 12'h000;
    localparam logic [ADDR_W-1:0] WGT_BASE  = 12'h040;
    localparam logic [ADDR_W-1:0] CTRL_ADDR = 12'h080;
    localparam logic [ADDR_W-1:0] STAT_ADDR = 12'h084;
    localparam logic [ADDR_W-1:0] RES_BASE  = 12'h100;

    localparam int IMG_WORDS = 16;
    localparam int WGT_WORDS = 7;
    localparam int RES_WORDS = 27;

    // storage region selects on the host side of the feature buffer.
    localparam logic [1:0] SEL_IMG = 2'd0;
    localparam logic [1:0] SEL_WGT = 2'd1;
    localparam logic [1:0] SEL_RES = 2'd2;

    function automatic logic in_region(logic [ADDR_W-1:0] addr, logic [ADDR_W-1:0] base,
                                       int words);
        return (addr >= base) && (addr < base + ADDR_W'(words * 4));
    endfunction

endpackage

`default_nettype wire

// File: conv_engine/tap_counter.sv
`timescale 1ns/100ps
`default_nettype none

module tap_counter import conv_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       run,
    output tap_t       tap,
    output logic [1:0] krow,
    output logic [1:0] kcol,
    output logic       last
);

    assign last = (tap == tap_t'(NUM_TAPS - 1));

    // kernel row and column step along with the tap so the pixel address needs no divide.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tap  <= '0;
            krow <= '0;
            kcol <= '0;
        end else if (run) begin
            if (last) begin
                tap  <= '0;
                krow <= '0;
                kcol <= '0;
            end else begin
                tap <= tap + tap_t'(1);
                if (kcol == 2'(K_DIM - 1)) begin
                    kcol <= '0;
                    krow <= krow + 2'd1;
                end else begin
                    kcol <= kcol + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: conv_engine/conv_mac.sv
`timescale 1ns/100ps
`default_nettype none

module conv_mac import conv_pkg::*; #(
    parameter int OUT_SHIFT = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  mac_op_e op,
    input  pixel_t  pixel,
    input  weight_t weight,
    output pixel_t  result
);

    acc_t acc;
    acc_t product;
    acc_t shifted;

    // the pixel is unsigned, so it gets a zero sign bit before the signed multiply.
    assign product = $signed({1'b0, pixel}) * weight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else begin
            case (op)
                MAC_CLEAR: acc <= '0;
                MAC_ACC:   acc <= acc + product;
                default:   acc <= acc;
            endcase
        end
    end

    assign shifted = acc >>> OUT_SHIFT;

    always_comb begin
        if (acc < 0)
            result = '0;           // negative sums clamp to zero.
        else if (shifted > 255)
            result = 8'hff;
        else
            result = shifted[7:0];
    end

endmodule

`default_nettype wire

// File: conv_engine/conv_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module conv_ctrl import conv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,
    input  logic    tap_last,
    output logic    run,
    output mac_op_e mac_op,
    output logic    commit,
    output pos_t    pos,
    output logic    busy,
    output logic    done_pulse
);

    localparam logic [2:0] LAST_IDX = 3'(OUT_DIM - 1);

    ctrl_state_e state;
    logic        last_pos;

    assign last_pos = (pos.row == LAST_IDX) && (pos.col == LAST_IDX);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pos   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= CLEAR;
                        pos   <= '0;
                    end
                end
                CLEAR:
                    state <= RUN;
                RUN: begin
                    if (tap_last)
                        state <= COMMIT;
                end
                COMMIT: begin
                    // the window sum is stored this cycle, so the position moves on after it.
                    if (last_pos) begin
                        state <= DONE;
                        pos   <= '0;
                    end else begin
                        state <= CLEAR;
                        if (pos.col == LAST_IDX) begin
                            pos.col <= '0;
                            pos.row <= pos.row + 3'd1;
                        end else begin
                            pos.col <= pos.col + 3'd1;
                        end
                    end
                end
                DONE:
                    state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_comb begin
        case (state)
            CLEAR:   mac_op = MAC_CLEAR;
            RUN:     mac_op = MAC_ACC;
            default: mac_op = MAC_HOLD;
        endcase
    end

    assign run        = (state == RUN);
    assign commit     = (state == COMMIT);
    assign busy       = (state != IDLE);  // 36 positions of 11 cycles plus the done cycle.
    assign done_pulse = (state == DONE);

endmodule

`default_nettype wire

// File: conv_engine/feature_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module feature_buffer import conv_pkg::*, axil_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   host_we,
    input  logic [1:0]             host_region,
    input  logic [3:0]             host_widx,
    input  logic [DATA_W-1:0]      host_wdata,
    input  logic [4:0]             host_ridx,
    input  logic [1:0]             host_rsel,
    output logic [DATA_W-1:0]      host_rdata,
    input  pos_t                   pos,
    input  logic [1:0]             krow,
    input  logic [1:0]             kcol,
    input  tap_t                   tap,
    output pixel_t                 pixel,
    output weight_t [NUM_FILT-1:0] weights,
    input  logic                   commit,
    input  pixel_t  [NUM_FILT-1:0] results
);

    localparam int NUM_PIX = IMG_DIM * IMG_DIM;
    localparam int NUM_WGT = NUM_FILT * NUM_TAPS;
    localparam int MAP_SZ  = OUT_DIM * OUT_DIM;
    localparam int NUM_RES = NUM_FILT * MAP_SZ;

    pixel_t  img_mem [NUM_PIX];
    weight_t wgt_mem [NUM_WGT];
    pixel_t  res_mem [NUM_RES];

    logic [2:0] pix_row, pix_col;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PIX; i++)
                img_mem[i] <= '0;
            for (int i = 0; i < NUM_WGT; i++)
                wgt_mem[i] <= '0;
        end else if (host_we) begin
            for (int i = 0; i < 4; i++) begin
                if (host_region == SEL_WGT) begin
                    if (host_widx * 4 + i < NUM_WGT)  // the top byte of the last word is spare.
                        wgt_mem[host_widx * 4 + i] <= host_wdata[i*8 +: 8];
                end else begin
                    img_mem[host_widx * 4 + i] <= host_wdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_RES; i++)
                res_mem[i] <= '0;
        end else if (commit) begin
            for (int f = 0; f < NUM_FILT; f++)
                res_mem[f * MAP_SZ + pos.row * OUT_DIM + pos.col] <= results[f];
        end
    end

    always_comb begin
        host_rdata = '0;
        for (int i = 0; i < 4; i++) begin
            case (host_rsel)
                SEL_IMG:
                    host_rdata[i*8 +: 8] = img_mem[host_ridx[3:0] * 4 + i];
                SEL_WGT:
                    if (host_ridx * 4 + i < NUM_WGT)
                        host_rdata[i*8 +: 8] = wgt_mem[host_ridx * 4 + i];
                SEL_RES:
                    if (host_ridx * 4 + i < NUM_RES)
                        host_rdata[i*8 +: 8] = res_mem[host_ridx * 4 + i];
                default:
                    host_rdata[i*8 +: 8] = '0;
            endcase
        end
    end

    // with an 8-wide image the pixel index is just row and column side by side.
    assign pix_row = pos.row + 3'(krow);
    assign pix_col = pos.col + 3'(kcol);
    assign pixel   = img_mem[{pix_row, pix_col}];

    always_comb begin
        for (int f = 0; f < NUM_FILT; f++)
            weights[f] = wgt_mem[f * NUM_TAPS + tap];
    end

endmodule

`default_nettype wire

// File: src/conv_axil_slave.sv
`timescale 1ns/100ps
`default_nettype none

module conv_axil_slave import axil_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  axil_aw_t          aw,
    output logic              awready,
    input  axil_w_t           w,
    output logic              wready,
    output axil_b_t           b,
    input  logic              bready,
    input  axil_ar_t          ar,
    output logic              arready,
    output axil_r_t           r,
    input  logic              rready,
    output logic              host_we,
    output logic [1:0]        host_region,
    output logic [3:0]        host_widx,
    output logic [DATA_W-1:0] host_wdata,
    output logic [4:0]        host_ridx,
    output logic [1:0]        host_rsel,
    input  logic [DATA_W-1:0] host_rdata,
    output logic              start,
    input  logic              busy,
    input  logic              done
);

    logic              aw_hs, ar_hs;
    logic              wr_img, wr_wgt, wr_ctrl, wr_ok;
    logic              rd_img, rd_wgt, rd_res, rd_stat, rd_ctrl;
    logic [ADDR_W-1:0] wr_off, rd_off;
    logic [DATA_W-1:0] rd_data;
    logic              done_q;

    // a write is taken only with address and data together.
    assign aw_hs   = aw.valid && w.valid && !b.valid;
    assign awready = aw_hs;
    assign wready  = aw_hs;

    assign wr_img  = in_region(aw.addr, IMG_BASE, IMG_WORDS);
    assign wr_wgt  = in_region(aw.addr, WGT_BASE, WGT_WORDS);
    assign wr_ctrl = (aw.addr[ADDR_W-1:2] == CTRL_ADDR[ADDR_W-1:2]);
    assign wr_ok   = wr_ctrl || ((wr_img || wr_wgt) && !busy);

    assign wr_off      = wr_wgt ? aw.addr - WGT_BASE : aw.addr - IMG_BASE;
    assign host_we     = aw_hs && (wr_img || wr_wgt) && !busy;
    assign host_region = wr_wgt ? SEL_WGT : SEL_IMG;
    assign host_widx   = wr_off[5:2];
    assign host_wdata  = w.data;

    assign start = aw_hs && wr_ctrl && w.data[0] && !busy;  // a start while busy is dropped.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            b <= '0;
        end else if (aw_hs) begin
            b.valid <= 1'b1;
            b.resp  <= wr_ok ? OKAY : SLVERR;
        end else if (bready) begin
            b.valid <= 1'b0;
        end
    end

    assign arready = !r.valid;
    assign ar_hs   = ar.valid && !r.valid;

    assign rd_img  = in_region(ar.addr, IMG_BASE, IMG_WORDS);
    assign rd_wgt  = in_region(ar.addr, WGT_BASE, WGT_WORDS);
    assign rd_res  = in_region(ar.addr, RES_BASE, RES_WORDS);
    assign rd_stat = (ar.addr[ADDR_W-1:2] == STAT_ADDR[ADDR_W-1:2]);
    assign rd_ctrl = (ar.addr[ADDR_W-1:2] == CTRL_ADDR[ADDR_W-1:2]);

    always_comb begin
        if (rd_res) begin
            rd_off    = ar.addr - RES_BASE;
            host_rsel = SEL_RES;
        end else if (rd_wgt) begin
            rd_off    = ar.addr - WGT_BASE;
            host_rsel = SEL_WGT;
        end else begin
            rd_off    = ar.addr - IMG_BASE;
            host_rsel = SEL_IMG;
        end
    end

    assign host_ridx = rd_off[6:2];

    always_comb begin
        if (rd_img || rd_wgt || rd_res)
            rd_data = host_rdata;
        else if (rd_stat)
            rd_data = {{(DATA_W-2){1'b0}}, done_q, busy};
        else
            rd_data = '0;  // control reads back as zero.
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            r <= '0;
        end else if (ar_hs) begin
            r.valid <= 1'b1;
            r.data  <= rd_data;
            r.resp  <= (rd_img || rd_wgt || rd_res || rd_stat || rd_ctrl) ? OKAY : SLVERR;
        end else if (rready) begin
            r.valid <= 1'b0;
        end
    end

    // done stays set until the next accepted start.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            done_q <= 1'b0;
        else if (start)
            done_q <= 1'b0;
        else if (done)
            done_q <= 1'b1;
    end

endmodule

`default_nettype wire

// File: src/conv_accel_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_accel_top import conv_pkg::*, axil_pkg::*; #(
    parameter int OUT_SHIFT = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  axil_aw_t aw,
    output logic     awready,
    input  axil_w_t  w,
    output logic     wready,
    output axil_b_t  b,
    input  logic     bready,
    input  axil_ar_t ar,
    output logic     arready,
    output axil_r_t  r,
    input  logic     rready
);

    logic              host_we;
    logic [1:0]        host_region, host_rsel;
    logic [3:0]        host_widx;
    logic [4:0]        host_ridx;
    logic [DATA_W-1:0] host_wdata, host_rdata;
    logic              start, busy, done_pulse;
    logic              run, commit, tap_last;
    logic [1:0]        krow, kcol;
    tap_t              tap;
    pos_t              pos;
    mac_op_e           mac_op;
    pixel_t            pixel;
    weight_t [NUM_FILT-1:0] weights;
    pixel_t  [NUM_FILT-1:0] results;

    conv_axil_slave u_slave (
        .clk, .rst_n,
        .aw, .awready, .w, .wready, .b, .bready,
        .ar, .arready, .r, .rready,
        .host_we, .host_region, .host_widx, .host_wdata,
        .host_ridx, .host_rsel, .host_rdata,
        .start, .busy, .done(done_pulse)
    );

    feature_buffer u_buffer (
        .clk, .rst_n,
        .host_we, .host_region, .host_widx, .host_wdata,
        .host_ridx, .host_rsel, .host_rdata,
        .pos, .krow, .kcol, .tap,
        .pixel, .weights, .commit, .results
    );

    conv_ctrl u_ctrl (
        .clk, .rst_n, .start, .tap_last,
        .run, .mac_op, .commit, .pos, .busy, .done_pulse
    );

    tap_counter u_taps (
        .clk, .rst_n, .run, .tap, .krow, .kcol, .last(tap_last)
    );

    // all filters see the same pixel, each with its own weight.
    for (genvar f = 0; f < NUM_FILT; f++) begin : g_mac
        conv_mac #(.OUT_SHIFT(OUT_SHIFT)) u_mac (
            .clk, .rst_n, .op(mac_op), .pixel,
            .weight(weights[f]), .result(results[f])
        );
    end

endmodule

`default_nettype wire

// File: tests/tb_conv_accel.sv
`timescale 1ns/100ps
`default_nettype none

module tb_conv_accel import conv_pkg::*, axil_pkg::*; ();

    localparam int TB_SHIFT       = 4;
    localparam int TIMEOUT_CYCLES = 5000;  // three runs of 397 cycles plus register traffic.

    logic     clk;
    logic     rst_n;
    axil_aw_t aw;
    axil_w_t  w;
    axil_b_t  b;
    axil_ar_t ar;
    axil_r_t  r;
    logic     awready, wready, arready;
    logic     bready, rready;
    int       cycle_count;

    pixel_t  img [IMG_DIM*IMG_DIM];
    weight_t wgt [NUM_FILT][NUM_TAPS];

    conv_accel_top #(.OUT_SHIFT(TB_SHIFT)) u_conv_accel_top (
        .clk, .rst_n,
        .aw, .awready, .w, .wready, .b, .bready,
        .ar, .arready, .r, .rready
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            report_failure("Timeout: the run did not finish within the cycle limit.");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp)
            report_failure($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
        if (got !== exp)
            report_failure($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            report_failure($sformatf("Error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // the model takes the signed window sum, clamps it at zero, then shifts and saturates it.
    function automatic pixel_t model_pixel(input int f, input int row, input int col);
        int sum;
        int scaled;
        sum = 0;
        for (int kr = 0; kr < K_DIM; kr++)
            for (int kc = 0; kc < K_DIM; kc++)
                sum += int'(img[(row + kr) * IMG_DIM + col + kc]) * int'(wgt[f][kr * K_DIM + kc]);
        if (sum < 0)
            sum = 0;
        scaled = sum >>> TB_SHIFT;
        if (scaled > 255)
            return 8'hff;
        return pixel_t'(scaled);
    endfunction

    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data,
                              input axil_resp_e exp_resp);
        @(negedge clk);
        aw.addr  = addr;
        aw.valid = 1'b1;
        w.data   = data;
        w.valid  = 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        if (!wready)
            report_failure($sformatf("wready did not rise together with awready at 0x%h.", addr));
        @(negedge clk);
        aw.valid = 1'b0;
        w.valid  = 1'b0;
        while (!b.valid) @(negedge clk);
        check_resp($sformatf("bresp[0x%h]", addr), b.resp, exp_resp);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [11:0] addr, input axil_resp_e exp_resp,
                             output logic [31:0] data);
        @(negedge clk);
        ar.addr  = addr;
        ar.valid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        @(negedge clk);
        ar.valid = 1'b0;
        while (!r.valid) @(negedge clk);
        check_resp($sformatf("rresp[0x%h]", addr), r.resp, exp_resp);
        data   = r.data;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic load_image();
        for (int k = 0; k < IMG_WORDS; k++)
            axil_write(IMG_BASE + 12'(k * 4),
                       {img[k*4+3], img[k*4+2], img[k*4+1], img[k*4]}, OKAY);
    endtask

    task automatic load_weights();
        logic [31:0] word;
        int          n;
        for (int j = 0; j < WGT_WORDS; j++) begin
            word = '0;
            for (int i = 0; i < 4; i++) begin
                n = j * 4 + i;
                if (n < NUM_FILT * NUM_TAPS)
                    word[i*8 +: 8] = wgt[n / NUM_TAPS][n % NUM_TAPS];
            end
            axil_write(WGT_BASE + 12'(j * 4), word, OKAY);
        end
    endtask

    task automatic check_results();
        logic [31:0] word;
        int          n, f, row, col;
        for (int j = 0; j < RES_WORDS; j++) begin
            axil_read(RES_BASE + 12'(j * 4), OKAY, word);
            for (int i = 0; i < 4; i++) begin
                n   = j * 4 + i;
                f   = n / (OUT_DIM * OUT_DIM);
                row = (n % (OUT_DIM * OUT_DIM)) / OUT_DIM;
                col = n % OUT_DIM;
                check_pixel($sformatf("result[%0d][%0d][%0d]", f, row, col),
                            word[i*8 +: 8], model_pixel(f, row, col));
            end
        end
    endtask

    task automatic wait_done();
        logic [31:0] stat;
        stat = '0;
        while (!stat[1])
            axil_read(STAT_ADDR, OKAY, stat);  // the cycle counter bounds this loop.
    endtask

    task automatic run_conv();
        axil_write(CTRL_ADDR, 32'h1, OKAY);
        wait_done();
    endtask

    task automatic test_reset_state();
        logic [31:0] stat;
        axil_read(STAT_ADDR, OKAY, stat);
        check_word("stat", stat, 32'h0);
        check_results();  // the model arrays are still zero here.
    endtask

    task automatic test_known_kernels();
        for (int i = 0; i < IMG_DIM * IMG_DIM; i++)
            img[i] = 8'($urandom());
        for (int t = 0; t < NUM_TAPS; t++) begin
            wgt[0][t] = (t == 4) ? 8'sd16 : 8'sd0;
            wgt[1][t] = weight_t'(t - 4);
            wgt[2][t] = -8'sd1;          // every window sum is negative or zero.
        end
        load_image();
        load_weights();
        run_conv();
        check_results();
    endtask

    task automatic test_saturation_and_busy();
        logic [31:0] stat;
        for (int i = 0; i < IMG_DIM * IMG_DIM; i++)
            img[i] = 8'hff;
        for (int t = 0; t < NUM_TAPS; t++) begin
            wgt[0][t] = 8'sd127;
            wgt[1][t] = weight_t'($urandom());
            wgt[2][t] = weight_t'($urandom());
        end
        load_image();
        load_weights();
        axil_write(CTRL_ADDR, 32'h1, OKAY);
        axil_read(STAT_ADDR, OKAY, stat);
        check_word("stat", stat, 32'h1);
        axil_write(IMG_BASE, 32'h0, SLVERR);
        wait_done();
        axil_read(STAT_ADDR, OKAY, stat);
        check_word("stat", stat, 32'h2);
        check_results();
    endtask

    task automatic test_error_responses();
        logic [31:0] data;
        axil_write(RES_BASE, 32'h1234_5678, SLVERR);
        axil_write(12'h200, 32'hdead_beef, SLVERR);
        axil_read(12'h200, SLVERR, data);
        check_word("rdata", data, 32'h0);
        check_results();
    endtask

    task automatic test_second_run();
        logic [31:0] stat;
        for (int i = 0; i < IMG_DIM * IMG_DIM; i++)
            img[i] = 8'($urandom());
        for (int f = 0; f < NUM_FILT; f++)
            for (int t = 0; t < NUM_TAPS; t++)
                wgt[f][t] = weight_t'($urandom());
        load_image();
        load_weights();
        axil_write(CTRL_ADDR, 32'h1, OKAY);
        axil_read(STAT_ADDR, OKAY, stat);
        check_word("stat", stat, 32'h1);  // done from the last run is gone.
        wait_done();
        check_results();
    endtask

    initial begin
        int seed_val;
        seed_val    = $urandom(23140);
        clk         = 1'b0;
        rst_n       = 1'b0;
        aw          = '0;
        w           = '0;
        ar          = '0;
        bready      = 1'b0;
        rready      = 1'b0;
        cycle_count = 0;
        for (int i = 0; i < IMG_DIM * IMG_DIM; i++)
            img[i] = '0;
        for (int f = 0; f < NUM_FILT; f++)
            for (int t = 0; t < NUM_TAPS; t++)
                wgt[f][t] = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset_state();
        test_known_kernels();
        test_saturation_and_busy();
        test_error_responses();
        test_second_run();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
common/conv_pkg.sv
common/axil_pkg.sv
conv_engine/tap_counter.sv
conv_engine/conv_mac.sv
conv_engine/conv_ctrl.sv
conv_engine/feature_buffer.sv
src/conv_axil_slave.sv
src/conv_accel_top.sv
tests/tb_conv_accel.sv
